// File: hw/atan_pkg.sv
package atan_pkg;

    localparam int data_w  = 16;
    localparam int mag_w   = 16;
    localparam int angle_w = 16;                 // +-pi is +-2^15
    localparam int shift_w = $clog2(mag_w);
    localparam int iter_n  = 14;
    localparam int guard_w = 2;                  // headroom for the rotation gain
    localparam int rot_w   = mag_w + guard_w;

    localparam logic [shift_w-1:0] max_shift = shift_w'(10);
    localparam logic [shift_w-1:0] min_shift = shift_w'(3);
    localparam logic [shift_w-1:0] msb_idx   = shift_w'(mag_w - 1);

    localparam logic [mag_w-1:0]   mag_sat   = mag_w'((1 << (data_w - 1)) - 1);
    localparam logic [angle_w-1:0] half_turn = angle_w'(1 << (angle_w - 1));

    // atan(2^-i) scaled to pi/32768 per lsb
    localparam logic signed [angle_w-1:0] atan_table [iter_n] = '{
        16'sd8192, 16'sd4836, 16'sd2555, 16'sd1297,
        16'sd651,  16'sd326,  16'sd163,  16'sd81,
        16'sd41,   16'sd20,   16'sd10,   16'sd5,
        16'sd3,    16'sd1
    };

    typedef struct packed {
        logic signed [data_w-1:0] x;
        logic signed [data_w-1:0] y;
    } sample_t;

    typedef struct packed {
        logic x_neg;
        logic y_neg;
    } quad_t;

    typedef struct packed {
        logic [mag_w-1:0] mx;
        logic [mag_w-1:0] my;
    } mag_pair_t;

    typedef struct packed {
        logic signed [angle_w-1:0] angle;
        logic [shift_w-1:0]        shift;
    } result_t;

endpackage

// File: hw/quadrant_fold.sv
`timescale 1ns/1ps

module quadrant_fold (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  atan_pkg::sample_t   in_data,
    output logic                out_valid,
    input  logic                out_ready,
    output atan_pkg::mag_pair_t out_mag,
    output atan_pkg::quad_t     out_quad
);

    logic adv;

    // |v| with the most negative code pinned to the largest positive one
    function automatic logic [atan_pkg::mag_w-1:0] abs_sat(
        input logic signed [atan_pkg::data_w-1:0] v
    );
        if (v == {1'b1, {(atan_pkg::data_w - 1){1'b0}}})
            return atan_pkg::mag_sat;
        return (v < 0) ? -v : v;
    endfunction

    assign adv      = !out_valid || out_ready;
    assign in_ready = adv;

    always_ff @(posedge clk) begin
        if (rst)
            out_valid <= 1'b0;
        else if (adv)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            out_quad.x_neg <= in_data.x[atan_pkg::data_w-1];
            out_quad.y_neg <= in_data.y[atan_pkg::data_w-1];
            out_mag.mx     <= abs_sat(in_data.x);
            out_mag.my     <= abs_sat(in_data.y);
        end
    end

endmodule

// File: hw/first_one_finder.sv
`timescale 1ns/1ps

module first_one_finder (
    input  logic                        clk,
    input  logic                        en,
    input  logic [atan_pkg::mag_w-1:0]  din,
    output logic [atan_pkg::shift_w-1:0] pos
);

    logic [atan_pkg::shift_w-1:0] pos_d;

    // scan upward so the highest set bit wins
    always_comb begin
        pos_d = '0;                             // all zero reads as bit 0
        for (int i = 0; i < atan_pkg::mag_w; i++) begin
            if (din[i])
                pos_d = atan_pkg::shift_w'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (en)
            pos <= pos_d;
    end

endmodule

// File: hw/autoscale.sv
`timescale 1ns/1ps

module autoscale #(
    parameter type tag_t = logic
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  atan_pkg::mag_pair_t          in_mag,
    input  tag_t                         in_tag,
    output logic                         out_valid,
    input  logic                         out_ready,
    output atan_pkg::mag_pair_t          out_mag,
    output tag_t                         out_tag,
    output logic [atan_pkg::shift_w-1:0] shift
);

    logic                         adv;
    logic [2:0]                   v_q;          // valid of stages 1..3
    atan_pkg::mag_pair_t          mag_s1;
    atan_pkg::mag_pair_t          mag_s2;
    atan_pkg::mag_pair_t          mag_s3;
    tag_t                         tag_s1;
    tag_t                         tag_s2;
    tag_t                         tag_s3;
    logic [atan_pkg::mag_w-1:0]   ones_s1;      // mx | my, shared leading one
    logic [atan_pkg::shift_w-1:0] first_one;
    logic [atan_pkg::shift_w-1:0] raw_s3;
    logic [atan_pkg::shift_w-1:0] applied;

    assign adv      = !out_valid || out_ready;
    assign in_ready = adv;

    always_ff @(posedge clk) begin
        if (rst) begin
            v_q       <= '0;
            out_valid <= 1'b0;
        end else if (adv) begin
            v_q       <= {v_q[1:0], in_valid};
            out_valid <= v_q[2];
        end
    end

    // stage 2 position register lives in the finder
    first_one_finder u_ffo (
        .clk (clk),
        .en  (adv),
        .din (ones_s1),
        .pos (first_one)
    );

    // small raw shifts are not worth it, large ones would blow up noise
    always_comb begin
        if (raw_s3 > atan_pkg::max_shift)
            applied = atan_pkg::max_shift;
        else if (raw_s3 < atan_pkg::min_shift)
            applied = '0;
        else
            applied = raw_s3;
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            mag_s1     <= in_mag;               // stage 1
            tag_s1     <= in_tag;
            ones_s1    <= in_mag.mx | in_mag.my;
            mag_s2     <= mag_s1;               // stage 2
            tag_s2     <= tag_s1;
            raw_s3     <= atan_pkg::msb_idx - first_one;   // stage 3
            mag_s3     <= mag_s2;
            tag_s3     <= tag_s2;
            out_mag.mx <= mag_s3.mx << applied; // stage 4
            out_mag.my <= mag_s3.my << applied;
            out_tag    <= tag_s3;
            shift      <= applied;
        end
    end

endmodule

// File: hw/cordic_vectoring.sv
`timescale 1ns/1ps

module cordic_vectoring #(
    parameter type tag_t = logic
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  atan_pkg::mag_pair_t                in_mag,
    input  tag_t                               in_tag,
    input  logic [atan_pkg::shift_w-1:0]       in_shift,
    output logic                               out_valid,
    input  logic                               out_ready,
    output logic signed [atan_pkg::angle_w-1:0] out_angle,
    output tag_t                               out_tag,
    output logic [atan_pkg::shift_w-1:0]       out_shift
);

    localparam int n = atan_pkg::iter_n;

    logic                               adv;
    logic [n-1:0]                       v_q;
    // x stays non negative and may use the full width, y carries a sign
    logic [atan_pkg::rot_w-1:0]         x_q   [n-2];
    logic signed [atan_pkg::rot_w-1:0]  y_q   [n-1];
    logic signed [atan_pkg::angle_w-1:0] z_q  [n];
    tag_t                               tag_q [n];
    logic [atan_pkg::shift_w-1:0]       sh_q  [n];
    logic [atan_pkg::rot_w-1:0]         x_in  [n-1];
    logic signed [atan_pkg::rot_w-1:0]  y_in  [n];
    logic signed [atan_pkg::angle_w-1:0] z_in [n];
    logic [atan_pkg::rot_w-1:0]         x_sh  [n-1];
    logic signed [atan_pkg::rot_w-1:0]  y_sh  [n-2];

    assign adv      = !out_valid || out_ready;
    assign in_ready = adv;

    always_comb begin
        x_in[0] = {{atan_pkg::guard_w{1'b0}}, in_mag.mx};
        y_in[0] = signed'({{atan_pkg::guard_w{1'b0}}, in_mag.my});
        z_in[0] = '0;
        for (int i = 1; i < n - 1; i++)
            x_in[i] = x_q[i-1];
        for (int i = 1; i < n; i++) begin
            y_in[i] = y_q[i-1];
            z_in[i] = z_q[i-1];
        end
        for (int i = 0; i < n - 1; i++)
            x_sh[i] = x_in[i] >> i;
        for (int i = 0; i < n - 2; i++)
            y_sh[i] = y_in[i] >>> i;            // keep the sign of y
    end

    always_ff @(posedge clk) begin
        if (rst)
            v_q <= '0;
        else if (adv)
            v_q <= {v_q[n-2:0], in_valid};
    end

    // y == 0 means the residual angle is already zero, so hold
    always_ff @(posedge clk) begin
        if (adv) begin
            for (int i = 0; i < n; i++) begin
                if (y_in[i] == 0)
                    z_q[i] <= z_in[i];
                else if (y_in[i][atan_pkg::rot_w-1])
                    z_q[i] <= z_in[i] - atan_pkg::atan_table[i];
                else
                    z_q[i] <= z_in[i] + atan_pkg::atan_table[i];
            end
            for (int i = 0; i < n - 1; i++) begin
                if (y_in[i] == 0)
                    y_q[i] <= y_in[i];
                else if (y_in[i][atan_pkg::rot_w-1])
                    y_q[i] <= y_in[i] + x_sh[i];
                else
                    y_q[i] <= y_in[i] - x_sh[i];
            end
            for (int i = 0; i < n - 2; i++) begin
                if (y_in[i] == 0)
                    x_q[i] <= x_in[i];
                else if (y_in[i][atan_pkg::rot_w-1])
                    x_q[i] <= x_in[i] - y_sh[i];
                else
                    x_q[i] <= x_in[i] + y_sh[i];
            end
            tag_q[0] <= in_tag;
            sh_q[0]  <= in_shift;
            for (int i = 1; i < n; i++) begin
                tag_q[i] <= tag_q[i-1];
                sh_q[i]  <= sh_q[i-1];
            end
        end
    end

    assign out_valid = v_q[n-1];
    assign out_angle = z_q[n-1];
    assign out_tag   = tag_q[n-1];
    assign out_shift = sh_q[n-1];

endmodule

// File: hw/quadrant_restore.sv
`timescale 1ns/1ps

module quadrant_restore (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic signed [atan_pkg::angle_w-1:0] in_angle,
    input  atan_pkg::quad_t                     in_tag,
    input  logic [atan_pkg::shift_w-1:0]        in_shift,
    output logic                                out_valid,
    input  logic                                out_ready,
    output atan_pkg::result_t                   out_data
);

    logic                                adv;
    logic signed [atan_pkg::angle_w-1:0] angle_map;

    assign adv      = !out_valid || out_ready;
    assign in_ready = adv;

    // all sums wrap mod 2^16 so pi and -pi share one code
    always_comb begin
        case ({in_tag.x_neg, in_tag.y_neg})
            2'b10:   angle_map = atan_pkg::half_turn - in_angle;   // second quadrant
            2'b11:   angle_map = in_angle - atan_pkg::half_turn;   // third quadrant
            2'b01:   angle_map = -in_angle;
            default: angle_map = in_angle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            out_valid <= 1'b0;
        else if (adv)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            out_data.angle <= angle_map;
            out_data.shift <= in_shift;
        end
    end

endmodule

// File: hw/atan_top.sv
`timescale 1ns/1ps

module atan_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  atan_pkg::sample_t in_data,
    output logic              out_valid,
    input  logic              out_ready,
    output atan_pkg::result_t out_data
);

    logic                                fold_valid;
    logic                                fold_ready;
    atan_pkg::mag_pair_t                 fold_mag;
    atan_pkg::quad_t                     fold_quad;
    logic                                as_valid;
    logic                                as_ready;
    atan_pkg::mag_pair_t                 as_mag;
    atan_pkg::quad_t                     as_tag;
    logic [atan_pkg::shift_w-1:0]        as_shift;
    logic                                cv_valid;
    logic                                cv_ready;
    logic signed [atan_pkg::angle_w-1:0] cv_angle;
    atan_pkg::quad_t                     cv_tag;
    logic [atan_pkg::shift_w-1:0]        cv_shift;

    quadrant_fold u_fold (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (fold_valid),
        .out_ready (fold_ready),
        .out_mag   (fold_mag),
        .out_quad  (fold_quad)
    );

    autoscale #(.tag_t(atan_pkg::quad_t)) u_scale (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fold_valid),
        .in_ready  (fold_ready),
        .in_mag    (fold_mag),
        .in_tag    (fold_quad),
        .out_valid (as_valid),
        .out_ready (as_ready),
        .out_mag   (as_mag),
        .out_tag   (as_tag),
        .shift     (as_shift)
    );

    cordic_vectoring #(.tag_t(atan_pkg::quad_t)) u_cordic (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (as_valid),
        .in_ready  (as_ready),
        .in_mag    (as_mag),
        .in_tag    (as_tag),
        .in_shift  (as_shift),
        .out_valid (cv_valid),
        .out_ready (cv_ready),
        .out_angle (cv_angle),
        .out_tag   (cv_tag),
        .out_shift (cv_shift)
    );

    quadrant_restore u_restore (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (cv_valid),
        .in_ready  (cv_ready),
        .in_angle  (cv_angle),
        .in_tag    (cv_tag),
        .in_shift  (cv_shift),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

// File: verif/atan_chk.sv
`timescale 1ns/1ps

module atan_chk (
    input logic              clk,
    input logic              rst,
    input logic              out_valid,
    input logic              out_ready,
    input atan_pkg::result_t out_data
);

    int fail_count = 0;

    valid_low_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset");
            fail_count++;
        end

    // a stalled result stays put until it is taken
    data_held_on_stall: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else begin
            $error("out_data or out_valid changed while stalled");
            fail_count++;
        end

    shift_in_range: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (out_data.shift <= atan_pkg::max_shift))
        else begin
            $error("shift above the clamp limit");
            fail_count++;
        end

endmodule

bind atan_top atan_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

// File: verif/atan_tb.sv
`timescale 1ns/1ps

module atan_tb;

    localparam int max_vec   = 64;
    localparam int latency   = 1 + 4 + atan_pkg::iter_n + 1;
    localparam int angle_tol = 8;

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    atan_pkg::sample_t in_data;
    logic              out_valid;
    logic              out_ready;
    atan_pkg::result_t out_data;

    logic [15:0] vec_mem [0:4*max_vec-1];   // x, y, angle, shift per vector
    int          num_vec;
    int          cycle = 0;
    int          timeout_cycles;
    int          value_errors;
    int          other_errors;
    int          received;
    int          in_idx;
    int          last_out_cycle;
    bit          random_ready;
    bit          timing_check;
    int unsigned lcg_state;
    int          exp_q [$];                 // vector index of each accepted input
    int          in_cycle_q [$];

    atan_top uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // unloaded words keep this pattern, far above any valid shift
    function automatic logic [15:0] fill_word(input int addr);
        return ~addr[15:0];
    endfunction

    task automatic check_value(input string what, input int got, input int expected,
                               input int tol);
        int diff;
        diff = got - expected;
        if (diff > tol || diff < -tol) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            value_errors++;
        end
    endtask

    // one vector per accepted transfer, back to back while in_ready allows
    task automatic send_all();
        for (int i = 0; i < num_vec; i++) begin
            in_valid  = 1'b1;
            in_idx    = i;
            in_data.x = vec_mem[4*i];
            in_data.y = vec_mem[4*i+1];
            @(posedge clk);
            while (!in_ready)
                @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_results(input int target);
        while (received < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk) begin
        if (random_ready)
            out_ready <= #1 ((lcg_next() >> 16) % 4) != 0;   // ready about 3 of 4 cycles
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("timeout after %0d cycles with %0d of %0d results received",
                     cycle, received, 2 * num_vec);
            $display("Test failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (!rst && in_valid && in_ready) begin
            exp_q.push_back(in_idx);
            in_cycle_q.push_back(cycle);
        end
    end

    always @(posedge clk) begin
        int idx;
        int lat;
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("output at %0t ns with no input waiting for it", $time);
                other_errors++;
            end else begin
                idx = exp_q.pop_front();
                lat = cycle - in_cycle_q.pop_front();
                check_value($sformatf("vector %0d angle", idx), int'(out_data.angle),
                            int'($signed(vec_mem[4*idx+2])), angle_tol);
                check_value($sformatf("vector %0d shift", idx), int'(out_data.shift),
                            int'(vec_mem[4*idx+3]), 0);
                if (timing_check) begin
                    check_value($sformatf("vector %0d latency", idx), lat, latency, 0);
                    if (received > 0)
                        check_value("output spacing", cycle - last_out_cycle, 1, 0);
                end
            end
            last_out_cycle = cycle;
            received++;
        end
    end

    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        out_ready    = 1'b0;
        in_idx       = 0;
        random_ready = 1'b0;
        timing_check = 1'b0;
        value_errors = 0;
        other_errors = 0;
        received     = 0;
        lcg_state    = 10;
        for (int a = 0; a < 4 * max_vec; a++)
            vec_mem[a] = fill_word(a);
        $readmemh("verif/atan_vectors.txt", vec_mem);
        num_vec = 0;
        while (num_vec < max_vec && vec_mem[4*num_vec+3] != fill_word(4*num_vec+3))
            num_vec++;
        if (num_vec == 0) begin
            $display("no vectors could be read from verif/atan_vectors.txt");
            other_errors++;
        end
        timeout_cycles = 40 + 30 * 2 * num_vec;   // each vector goes through twice
        repeat (4) @(posedge clk);
        #1;
        rst          = 1'b0;
        out_ready    = 1'b1;
        timing_check = 1'b1;                      // first pass, no back-pressure
        send_all();
        wait_results(num_vec);
        timing_check = 1'b0;
        random_ready = 1'b1;
        send_all();
        wait_results(2 * num_vec);
        repeat (25) @(posedge clk);               // catch late duplicates
        #1;
        if (received != 2 * num_vec) begin
            $display("%0d results received, %0d inputs sent", received, 2 * num_vec);
            other_errors++;
        end
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, uut.u_chk.fail_count);
        if (value_errors + other_errors + uut.u_chk.fail_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: verif/atan_vectors.txt
// columns: x y angle shift, 16 bit two's complement hex
// angle lsb is pi/32768, shift is the applied normalizing shift
4000 0000 0000 0
0000 4000 4000 0
ffff 0000 8000 a
0000 0000 0000 a
0001 0001 2000 a
0bb8 0fa0 25c8 4
f448 0fa0 5a38 4
f448 f060 a5c8 4
0bb8 f060 da38 4
0064 0032 12e4 9
ff38 02bc 4b57 6
7530 4e20 17f5 0
b1e0 8ad0 a80b 0
8000 0000 8000 0
8000 8000 a000 0
0000 8000 c000 0
8000 7fff 6000 0
0018 0012 1a38 a
ffe8 ffee 9a38 a
1388 1388 2000 3
2000 2000 2000 0
0028 ffe2 e5c8 a

// File: build.f
hw/atan_pkg.sv
hw/quadrant_fold.sv
hw/first_one_finder.sv
hw/autoscale.sv
hw/cordic_vectoring.sv
hw/quadrant_restore.sv
hw/atan_top.sv
verif/atan_chk.sv
verif/atan_tb.sv

// File: Bender.yml
package:
  name: atan_unit

sources:
  - hw/atan_pkg.sv
  - hw/quadrant_fold.sv
  - hw/first_one_finder.sv
  - hw/autoscale.sv
  - hw/cordic_vectoring.sv
  - hw/quadrant_restore.sv
  - hw/atan_top.sv
  - target: test
    files:
      - verif/atan_chk.sv
      - verif/atan_tb.sv
